/* flist.f */
hdl/rover_cmd_pkg.sv
hdl/motor_pkg.sv
hdl/ir_nec_rx.sv
hdl/drive_mode_fsm.sv
hdl/motor_pwm.sv
hdl/rover_top.sv
test/rover_tb.sv

/* hdl/drive_mode_fsm.sv */
`timescale 1ns/1ps

module drive_mode_fsm import rover_cmd_pkg::*; (
    input  logic        clk_50,
    input  logic        rst_n,
    input  logic        key_valid,
    input  key_code_t   key,
    input  cam_report_t cam,
    output rover_mode_t mode,
    output cam_state_t  cam_state,
    output drive_t      drive
);

    rover_mode_t next_mode;
    cam_state_t  next_cam_state;
    drive_t      next_drive;
    drive_t      cam_drive;
    drive_t      man_drive;
    drive_t      man_speed;
    drive_t      next_man_speed;

    always_comb begin
        next_mode = mode;
        if (key_valid) begin
            case (key)
                key_cam:  next_mode = mode_cam;
                key_ir:   next_mode = mode_ir;
                key_idle: next_mode = mode_idle;
                default:  next_mode = mode;          // other keys keep the mode.
            endcase
        end
    end

    always_comb begin
        if (next_mode != mode_cam) begin
            next_cam_state = cam_pause;
        end else if (cam_state == cam_pause) begin
            next_cam_state = cam_search;             // fresh entry always searches first.
        end else begin
            next_cam_state = cam.orange ? cam_follow : cam_search;
        end
    end

    always_comb begin
        cam_drive = drv_stop;
        if (next_cam_state == cam_search) begin
            cam_drive = drv_right;                   // spin in place to look.
        end else if (next_cam_state == cam_follow) begin
            case (cam.dir)
                dir_left:   cam_drive = drv_left;
                dir_right:  cam_drive = drv_right;
                dir_center: begin
                    case (cam.speed)
                        spd_slow:   cam_drive = drv_slow;
                        spd_medium: cam_drive = drv_medium;
                        spd_fast:   cam_drive = drv_fast;
                        default:    cam_drive = drv_stop;
                    endcase
                end
                default: cam_drive = drv_stop;
            endcase
        end
    end

    always_comb begin
        man_drive      = drive;
        next_man_speed = man_speed;
        if (mode != mode_ir) begin
            man_drive = drv_stop;                    // just entering manual mode.
        end else if (key_valid) begin
            case (key)
                key_left:  man_drive = drv_left;
                key_right: man_drive = drv_right;
                key_stop:  man_drive = drv_stop;
                key_fwd:   man_drive = man_speed;
                key_slow, key_medium, key_fast: begin
                    next_man_speed = (key == key_slow) ? drv_slow :
                                     (key == key_medium) ? drv_medium : drv_fast;
                    if (drive inside {drv_slow, drv_medium, drv_fast}) begin
                        man_drive = next_man_speed;  // retune while rolling.
                    end
                end
                default: man_drive = drive;
            endcase
        end
    end

    always_comb begin
        case (next_mode)
            mode_cam: next_drive = cam_drive;
            mode_ir:  next_drive = man_drive;
            default:  next_drive = drv_stop;
        endcase
    end

    always_ff @(posedge clk_50 or negedge rst_n) begin
        if (!rst_n) begin
            mode      <= mode_idle;
            cam_state <= cam_pause;
            drive     <= drv_stop;
            man_speed <= drv_medium;
        end else begin
            mode      <= next_mode;
            cam_state <= next_cam_state;
            drive     <= next_drive;
            man_speed <= next_man_speed;
        end
    end

endmodule

/* hdl/ir_nec_rx.sv */
`timescale 1ns/1ps

module ir_nec_rx import rover_cmd_pkg::*; #(
    parameter int unit_cycles = 28125
) (
    input  logic      clk_50,
    input  logic      rst_n,
    input  logic      ir_in,
    output logic      key_valid,
    output key_code_t key
);

    // lengths are measured in quarter units for the 25 % window
    localparam int q_cycles = (unit_cycles >= 4) ? unit_cycles / 4 : 1;
    localparam int presc_w  = (q_cycles > 1) ? $clog2(q_cycles) : 1;

    typedef enum logic [2:0] {
        st_hunt,
        st_lead_burst,
        st_lead_space,
        st_bit_burst,
        st_bit_space,
        st_trailer
    } rx_state_t;

    logic               ir_s1;
    logic               ir_s2;
    logic               ir_d;
    logic               rise;
    logic               fall;
    logic [presc_w-1:0] presc;
    logic [6:0]         len;
    logic               space_zero;
    logic               space_one;
    logic               frame_ok;
    rx_state_t          state;
    logic [4:0]         bit_cnt;
    logic [31:0]        frame;

    // the count reads one quarter short of the time elapsed.
    function automatic logic len_ok(input logic [6:0] l, input int units);
        return (int'(l) >= 3 * units - 1) && (int'(l) <= 5 * units - 1);
    endfunction

    always_ff @(posedge clk_50 or negedge rst_n) begin
        if (!rst_n) begin
            ir_s1 <= 1'b1;                           // line idles high.
            ir_s2 <= 1'b1;
            ir_d  <= 1'b1;
        end else begin
            ir_s1 <= ir_in;
            ir_s2 <= ir_s1;
            ir_d  <= ir_s2;
        end
    end

    assign rise = ir_s2 & ~ir_d;                     // end of a burst.
    assign fall = ~ir_s2 & ir_d;                     // start of a burst.

    always_ff @(posedge clk_50 or negedge rst_n) begin
        if (!rst_n) begin
            presc <= '0;
            len   <= '0;
        end else if (rise || fall) begin
            presc <= '0;
            len   <= '0;
        end else if (presc == presc_w'(q_cycles - 1)) begin
            presc <= '0;
            if (len != 7'h7f) begin
                len <= len + 7'd1;                   // saturates well past any legal pulse.
            end
        end else begin
            presc <= presc + 1'b1;
        end
    end

    assign space_zero = len_ok(len, 1);
    assign space_one  = len_ok(len, 3);
    assign frame_ok   = (frame[23:16] == ~frame[31:24]);

    always_ff @(posedge clk_50 or negedge rst_n) begin
        if (!rst_n) begin
            state     <= st_hunt;
            bit_cnt   <= '0;
            key_valid <= 1'b0;
        end else begin
            key_valid <= 1'b0;
            case (state)
                st_hunt: begin
                    if (fall) state <= st_lead_burst;
                end
                st_lead_burst: begin
                    if (rise) state <= len_ok(len, 16) ? st_lead_space : st_hunt;
                end
                st_lead_space: begin
                    if (fall) begin
                        bit_cnt <= '0;
                        // a bad space may still open a fresh leader.
                        state   <= len_ok(len, 8) ? st_bit_burst : st_lead_burst;
                    end
                end
                st_bit_burst: begin
                    if (rise) state <= space_zero ? st_bit_space : st_hunt;
                end
                st_bit_space: begin
                    if (fall) begin
                        if (space_zero || space_one) begin
                            bit_cnt <= bit_cnt + 5'd1;
                            state   <= (bit_cnt == 5'd31) ? st_trailer : st_bit_burst;
                        end else begin
                            state <= st_lead_burst;
                        end
                    end
                end
                st_trailer: begin
                    if (rise) begin
                        key_valid <= space_zero && frame_ok;
                        state     <= st_hunt;
                    end
                end
                default: state <= st_hunt;
            endcase
        end
    end

    always_ff @(posedge clk_50) begin
        if (state == st_bit_space && fall && (space_zero || space_one)) begin
            frame <= {space_one, frame[31:1]};       // lsb first.
        end
        if (state == st_trailer && rise) begin
            key <= frame[23:16];                     // command byte.
        end
    end

endmodule

/* hdl/motor_pkg.sv */
package motor_pkg;

    // polarity of the h-bridge direction input
    typedef enum logic {
        whl_fwd = 1'b0,
        whl_rev = 1'b1
    } wheel_dir_t;

    typedef struct packed {
        wheel_dir_t dir;                             // wheel rotation sense.
        logic       pwm;                             // enable, chopped at the pwm rate.
    } wheel_cmd_t;

endpackage

/* hdl/motor_pwm.sv */
`timescale 1ns/1ps

module motor_pwm import rover_cmd_pkg::*, motor_pkg::*; #(
    parameter int pwm_bits    = 8,
    parameter int duty_slow   = 64,
    parameter int duty_medium = 128,
    parameter int duty_fast   = 224,
    parameter int duty_turn   = 96
) (
    input  logic       clk_50,
    input  logic       rst_n,
    input  drive_t     drive,
    output wheel_cmd_t wheel_left,
    output wheel_cmd_t wheel_right
);

    logic [pwm_bits-1:0] cnt;
    logic [pwm_bits-1:0] cnt_next;
    logic                wrap;
    drive_t              drive_q;
    drive_t              drive_sel;
    logic [pwm_bits:0]   duty_sel;
    logic                pwm_q;

    // high count per period, one bit wider so full on fits
    function automatic logic [pwm_bits:0] duty_of(input drive_t d);
        case (d)
            drv_slow:            return (pwm_bits + 1)'(duty_slow);
            drv_medium:          return (pwm_bits + 1)'(duty_medium);
            drv_fast:            return (pwm_bits + 1)'(duty_fast);
            drv_left, drv_right: return (pwm_bits + 1)'(duty_turn);
            default:             return '0;
        endcase
    endfunction

    assign wrap      = &cnt;                         // last count of the period.
    assign cnt_next  = cnt + 1'b1;
    assign drive_sel = wrap ? drive : drive_q;       // value in force for cnt_next.
    assign duty_sel  = duty_of(drive_sel);

    always_ff @(posedge clk_50 or negedge rst_n) begin
        if (!rst_n) begin
            cnt     <= '0;
            drive_q <= drv_stop;
            pwm_q   <= 1'b0;
        end else begin
            cnt   <= cnt_next;
            pwm_q <= ({1'b0, cnt_next} < duty_sel);  // high for the first duty counts.
            if (wrap) begin
                drive_q <= drive;
            end
        end
    end

    always_comb begin
        wheel_left.dir  = whl_fwd;
        wheel_right.dir = whl_fwd;
        case (drive_q)
            drv_left:  wheel_left.dir  = whl_rev;    // spin left in place.
            drv_right: wheel_right.dir = whl_rev;
            default:   wheel_left.dir  = whl_fwd;
        endcase
        wheel_left.pwm  = pwm_q;
        wheel_right.pwm = pwm_q;
    end

endmodule

/* hdl/rover_cmd_pkg.sv */
package rover_cmd_pkg;

    typedef logic [7:0] key_code_t;                  // nec command byte.

    localparam key_code_t key_cam    = 8'h0f;        // camera tracking.
    localparam key_code_t key_ir     = 8'h13;        // manual remote driving.
    localparam key_code_t key_idle   = 8'h10;
    localparam key_code_t key_fwd    = 8'h18;
    localparam key_code_t key_left   = 8'h08;
    localparam key_code_t key_right  = 8'h5a;
    localparam key_code_t key_stop   = 8'h1c;
    localparam key_code_t key_slow   = 8'h45;        // manual speed select.
    localparam key_code_t key_medium = 8'h46;
    localparam key_code_t key_fast   = 8'h47;

    typedef enum logic [1:0] {mode_idle = 2'b00, mode_cam = 2'b01, mode_ir = 2'b10} rover_mode_t;

    typedef enum logic [1:0] {cam_search = 2'b00, cam_follow = 2'b01, cam_pause = 2'b11} cam_state_t;

    typedef enum logic [2:0] {
        drv_stop   = 3'b000,
        drv_left   = 3'b001,
        drv_right  = 3'b010,
        drv_slow   = 3'b011,
        drv_medium = 3'b100,
        drv_fast   = 3'b101
    } drive_t;

    typedef logic [2:0] cam_dir_t;                   // other codes carry no direction.

    localparam cam_dir_t dir_left   = 3'b001;
    localparam cam_dir_t dir_right  = 3'b010;
    localparam cam_dir_t dir_center = 3'b011;

    localparam logic [1:0] spd_slow   = 2'd0;        // 3 means no speed estimate.
    localparam logic [1:0] spd_medium = 2'd1;
    localparam logic [1:0] spd_fast   = 2'd2;

    typedef struct packed {
        logic       orange;                          // target seen.
        cam_dir_t   dir;
        logic [1:0] speed;
    } cam_report_t;

endpackage

/* hdl/rover_top.sv */
`timescale 1ns/1ps

module rover_top import rover_cmd_pkg::*, motor_pkg::*; #(
    parameter int unit_cycles = 28125,
    parameter int pwm_bits    = 8,
    parameter int duty_slow   = 64,
    parameter int duty_medium = 128,
    parameter int duty_fast   = 224,
    parameter int duty_turn   = 96
) (
    input  logic        clk_50,
    input  logic        rst_n,
    input  logic        ir_in,
    input  cam_report_t cam,
    output rover_mode_t mode,
    output drive_t      drive,
    output wheel_cmd_t  wheel_left,
    output wheel_cmd_t  wheel_right
);

    logic       key_valid;
    key_code_t  key;
    cam_state_t cam_state;                           // search/follow/pause, kept inside.

    ir_nec_rx #(
        .unit_cycles(unit_cycles)
    ) ir_rx0 (
        .clk_50   (clk_50),
        .rst_n    (rst_n),
        .ir_in    (ir_in),
        .key_valid(key_valid),
        .key      (key)
    );

    drive_mode_fsm mode_fsm0 (
        .clk_50   (clk_50),
        .rst_n    (rst_n),
        .key_valid(key_valid),
        .key      (key),
        .cam      (cam),
        .mode     (mode),
        .cam_state(cam_state),
        .drive    (drive)
    );

    motor_pwm #(
        .pwm_bits   (pwm_bits),
        .duty_slow  (duty_slow),
        .duty_medium(duty_medium),
        .duty_fast  (duty_fast),
        .duty_turn  (duty_turn)
    ) motor0 (
        .clk_50     (clk_50),
        .rst_n      (rst_n),
        .drive      (drive),
        .wheel_left (wheel_left),
        .wheel_right(wheel_right)
    );

endmodule

/* run_sim.sh */
#!/bin/bash
# builds the rover testbench with verilator, runs it and scans the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --top-module rover_tb -f flist.f -o rover_sim \
    && ./obj_dir/rover_sim > sim.log 2>&1 \
    || echo "build or simulation returned an error"

grep -q "ALL CHECKS PASSED" sim.log 2>/dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }

exit 0

/* test/rover_tb.sv */
`timescale 1ns/1ps

module rover_tb import rover_cmd_pkg::*, motor_pkg::*; ();

    localparam int clk_period   = 20;
    localparam int unit_cycles  = 8;                 // short nec unit for simulation.
    localparam int pwm_period   = 256;               // 2**pwm_bits at the default width.
    localparam int duty_slow    = 64;
    localparam int duty_medium  = 128;
    localparam int duty_fast    = 224;
    localparam int duty_turn    = 96;
    localparam int key_latency  = 4;                 // frame end to new drive.
    localparam int cam_latency  = 1;
    localparam int frame_cycles = 160 * unit_cycles; // longest frame is 153 units.
    localparam int frame_count  = 16;
    localparam int pwm_windows  = 8;
    localparam int limit_cycles = frame_count * (frame_cycles + 16)
                                + pwm_windows * 3 * pwm_period + 2000;

    logic        clk_50;
    logic        rst_n;
    logic        ir_in;
    cam_report_t cam;
    rover_mode_t mode;
    drive_t      drive;
    wheel_cmd_t  wheel_left;
    wheel_cmd_t  wheel_right;
    integer      seed = 53;

    rover_top #(
        .unit_cycles(unit_cycles)
    ) dut0 (
        .clk_50     (clk_50),
        .rst_n      (rst_n),
        .ir_in      (ir_in),
        .cam        (cam),
        .mode       (mode),
        .drive      (drive),
        .wheel_left (wheel_left),
        .wheel_right(wheel_right)
    );

    initial clk_50 = 1'b0;
    always #10 clk_50 = ~clk_50;

    task automatic check(input string name, input int actual, input int expected);
        if (actual != expected) begin
            $display("error at %0t ns: %s is %0h, expected %0h", $time, name, actual, expected);
            $display("CHECKS FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // pwm high count per period for a drive value.
    function automatic int duty_for(input drive_t d);
        case (d)
            drv_slow:            return duty_slow;
            drv_medium:          return duty_medium;
            drv_fast:            return duty_fast;
            drv_left, drv_right: return duty_turn;
            default:             return 0;
        endcase
    endfunction

    task automatic hold_line(input logic level, input int units);
        ir_in <= level;                              // low is a burst.
        repeat (units * unit_cycles) @(posedge clk_50);
    endtask

    task automatic send_nec(input logic [7:0] addr, input key_code_t cmd, input bit corrupt);
        logic [7:0]  inv_cmd;
        logic [31:0] bits;
        inv_cmd = corrupt ? (~cmd ^ 8'h20) : ~cmd;
        bits    = {inv_cmd, cmd, ~addr, addr};       // sent lsb first.
        @(posedge clk_50);
        hold_line(1'b0, 16);
        hold_line(1'b1, 8);
        for (int i = 0; i < 32; i++) begin
            hold_line(1'b0, 1);
            hold_line(1'b1, bits[i] ? 3 : 1);
        end
        hold_line(1'b0, 1);                          // trailing burst.
        ir_in <= 1'b1;
    endtask

    task automatic send_key(input key_code_t cmd, input bit corrupt);
        logic [7:0] addr;
        addr = 8'($random(seed));                    // receiver ignores the address.
        send_nec(addr, cmd, corrupt);
        repeat (key_latency) @(posedge clk_50);
        @(negedge clk_50);
    endtask

    task automatic set_cam(input logic seen, input cam_dir_t dir, input logic [1:0] speed);
        @(posedge clk_50);
        cam.orange <= seen;
        cam.dir    <= dir;
        cam.speed  <= speed;
        repeat (cam_latency) @(posedge clk_50);
        @(negedge clk_50);
    endtask

    task automatic verify_mode_drive(input rover_mode_t m, input drive_t d);
        check("mode", int'(mode), int'(m));
        check("drive", int'(drive), int'(d));
    endtask

    task automatic reset_values();
        verify_mode_drive(mode_idle, drv_stop);
        for (int i = 0; i < pwm_period; i++) begin
            check("wheel_left.pwm", int'(wheel_left.pwm), 0);
            check("wheel_right.pwm", int'(wheel_right.pwm), 0);
            check("wheel_left.dir", int'(wheel_left.dir), int'(whl_fwd));
            check("wheel_right.dir", int'(wheel_right.dir), int'(whl_fwd));
            @(negedge clk_50);
        end
    endtask

    task automatic camera_tracking();
        set_cam(1'b0, 3'b000, 2'd3);
        send_key(key_cam, 1'b0);
        verify_mode_drive(mode_cam, drv_right);      // search spins right.
        set_cam(1'b1, dir_left, spd_slow);
        verify_mode_drive(mode_cam, drv_left);
        set_cam(1'b1, dir_right, spd_fast);
        verify_mode_drive(mode_cam, drv_right);
        set_cam(1'b1, dir_center, spd_slow);
        verify_mode_drive(mode_cam, drv_slow);
        set_cam(1'b1, dir_center, spd_medium);
        verify_mode_drive(mode_cam, drv_medium);
        set_cam(1'b1, dir_center, spd_fast);
        verify_mode_drive(mode_cam, drv_fast);
        set_cam(1'b1, 3'b111, spd_fast);
        verify_mode_drive(mode_cam, drv_stop);
        set_cam(1'b1, dir_center, 2'd3);             // centered but no speed.
        verify_mode_drive(mode_cam, drv_stop);
        set_cam(1'b0, dir_center, spd_fast);
        verify_mode_drive(mode_cam, drv_right);
    endtask

    task automatic frame_rejection();
        send_key(key_idle, 1'b1);
        verify_mode_drive(mode_cam, drv_right);
        send_key(key_idle, 1'b0);
        verify_mode_drive(mode_idle, drv_stop);
    endtask

    task automatic manual_driving();
        send_key(key_ir, 1'b0);
        verify_mode_drive(mode_ir, drv_stop);
        send_key(key_fwd, 1'b0);
        verify_mode_drive(mode_ir, drv_medium);      // default manual speed.
        send_key(key_fast, 1'b0);
        verify_mode_drive(mode_ir, drv_fast);
        send_key(key_fwd, 1'b0);
        verify_mode_drive(mode_ir, drv_fast);
        send_key(key_left, 1'b0);
        verify_mode_drive(mode_ir, drv_left);
        send_key(key_right, 1'b0);
        verify_mode_drive(mode_ir, drv_right);
        send_key(key_stop, 1'b0);
        verify_mode_drive(mode_ir, drv_stop);
        set_cam(1'b1, dir_center, spd_slow);
        verify_mode_drive(mode_ir, drv_stop);
        set_cam(1'b1, dir_left, spd_fast);
        verify_mode_drive(mode_ir, drv_stop);
        send_key(key_slow, 1'b0);                    // stored while stopped.
        verify_mode_drive(mode_ir, drv_stop);
        send_key(key_fwd, 1'b0);
        verify_mode_drive(mode_ir, drv_slow);
        send_key(key_idle, 1'b0);
        verify_mode_drive(mode_idle, drv_stop);
    endtask

    task automatic measure_pwm(input drive_t d);
        int         high_left;
        int         high_right;
        wheel_dir_t left_dir;
        wheel_dir_t right_dir;
        high_left  = 0;
        high_right = 0;
        left_dir   = (d == drv_left) ? whl_rev : whl_fwd;
        right_dir  = (d == drv_right) ? whl_rev : whl_fwd;
        // past the next wrap the new drive is latched.
        repeat (pwm_period + 4) @(negedge clk_50);
        for (int i = 0; i < pwm_period; i++) begin
            high_left  += int'(wheel_left.pwm);
            high_right += int'(wheel_right.pwm);
            check("wheel_left.dir", int'(wheel_left.dir), int'(left_dir));
            check("wheel_right.dir", int'(wheel_right.dir), int'(right_dir));
            @(negedge clk_50);
        end
        check("wheel_left high cycles", high_left, duty_for(d));
        check("wheel_right high cycles", high_right, duty_for(d));
    endtask

    task automatic pwm_case(input logic seen, input cam_dir_t dir, input logic [1:0] speed,
                            input drive_t d);
        set_cam(seen, dir, speed);
        verify_mode_drive(mode_cam, d);
        measure_pwm(d);
    endtask

    task automatic pwm_duties();
        set_cam(1'b0, 3'b000, 2'd3);
        send_key(key_cam, 1'b0);
        pwm_case(1'b0, 3'b000, 2'd3, drv_right);
        pwm_case(1'b1, dir_left, spd_slow, drv_left);
        pwm_case(1'b1, dir_center, spd_slow, drv_slow);
        pwm_case(1'b1, dir_center, spd_medium, drv_medium);
        pwm_case(1'b1, dir_center, spd_fast, drv_fast);
        pwm_case(1'b1, 3'b111, spd_fast, drv_stop);
    endtask

    initial begin
        rst_n <= 1'b0;
        ir_in <= 1'b1;                               // receiver line idles high.
        cam   <= '0;
        repeat (5) @(posedge clk_50);
        rst_n <= 1'b1;
        @(negedge clk_50);
        reset_values();
        camera_tracking();
        frame_rejection();
        manual_driving();
        pwm_duties();
        $display("ALL CHECKS PASSED");
        $finish;
    end

    initial begin
        #(limit_cycles * clk_period);
        $display("watchdog expired after %0d cycles, the tests did not finish", limit_cycles);
        $display("CHECKS FAILED");
        $fatal(1, "timeout");
    end

endmodule
